/* common/mips_addr_pkg.sv */
`default_nettype none

package mips_addr_pkg;

    // virtual address as issued by the fetch stage
    typedef logic [31:0] vaddr_t;

    // physical address after segment mapping or TLB translation
    typedef logic [31:0] paddr_t;

    // one instruction word
    typedef logic [31:0] word_t;

    // top two address bits of kseg0 and kseg1
    localparam logic [1:0] KSEG_TOP = 2'b10;

    // set in kseg1, which bypasses the cache
    localparam int KSEG1_BIT = 29;

endpackage

`default_nettype wire

/* common/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    // 4 KB virtual page number
    typedef logic [19:0] vpn_t;

    // even/odd page pair, vpn without its lowest bit
    typedef logic [18:0] vpn2_t;

    // physical frame number
    typedef logic [19:0] pfn_t;

    // joint TLB size and index
    localparam int TLB_ENTRIES = 8;
    typedef logic [2:0] tlb_idx_t;

endpackage

`default_nettype wire

/* icache/icache_bram.sv */
`default_nettype none

module icache_bram #(
    parameter int LEN_DATA = 64,
    parameter int LEN_ADDR = 9
) (
    input  logic                clk,
    input  logic [LEN_ADDR-1:0] wr_addr,
    input  logic [LEN_DATA-1:0] wr_data,
    input  logic [1:0]          wr_mask,
    input  logic [LEN_ADDR-1:0] rd_addr,
    output logic [LEN_DATA-1:0] rd_data
);

    localparam int HALF = LEN_DATA / 2;
    localparam int DEPTH = 1 << LEN_ADDR;

    logic [LEN_DATA-1:0] mem [DEPTH];

    // mask bit 0 covers the low half, bit 1 the upper half
    always_ff @(posedge clk) begin
        if (wr_mask[0]) begin
            mem[wr_addr][HALF-1:0] <= wr_data[HALF-1:0];
        end
        if (wr_mask[1]) begin
            mem[wr_addr][LEN_DATA-1:HALF] <= wr_data[LEN_DATA-1:HALF];
        end
    end

    // read during write returns the old contents
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* icache/icache.sv */
`default_nettype none

module icache
    import mips_addr_pkg::*;
    import tlb_pkg::*;
#(
    parameter int LEN_LINE  = 6,
    parameter int LEN_INDEX = 6
) (
    input  logic       clk,
    input  logic       rst,
    // fetch port
    input  logic       inst_en,
    input  vaddr_t     inst_va,
    input  vaddr_t     inst_va_next,
    output word_t      inst_rdata0,
    output word_t      inst_rdata1,
    output logic       inst_ok0,
    output logic       inst_ok1,
    output logic       inst_tlb_refill,
    output logic       inst_tlb_invalid,
    input  logic       stallF,
    output logic       istall,
    input  logic       fence_i,
    input  vaddr_t     fence_addr,
    input  logic       fence_tlb,
    // joint TLB lookup
    output vpn2_t      itlb_vpn2,
    input  logic       itlb_found,
    input  pfn_t       pfn0,
    input  pfn_t       pfn1,
    input  logic       c0,
    input  logic       c1,
    input  logic       v0,
    input  logic       v1,
    // AXI read channel
    output paddr_t     araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready
);

    localparam int LEN_PER_WAY = LEN_LINE + LEN_INDEX;
    localparam int LEN_TAG = 32 - LEN_PER_WAY;
    localparam int NR_LINES = 1 << LEN_INDEX;
    localparam int NR_WORDS = 1 << (LEN_LINE - 2);

    typedef logic [LEN_TAG-1:0] tag_t;
    typedef logic [LEN_INDEX-1:0] line_t;

    typedef enum logic [2:0] {
        idle, tlb_fill, uncached, cache_replace, save_result
    } state_t;

    state_t state;

    // per line valid bits and the way to replace next
    logic [1:0] line_valid [NR_LINES];
    logic       line_lru [NR_LINES];

    // one-entry L1 TLB
    vpn_t itlb_vpn;
    pfn_t itlb_pfn;
    logic itlb_uc;
    logic itlb_valid;
    logic tlb_wait;

    // refill bookkeeping
    line_t             repl_line;
    logic              repl_way;
    tag_t              repl_tag;
    logic [LEN_LINE-3:0] axi_cnt;

    word_t saved_inst0;
    logic  saved_ok0;

    // translation
    logic   direct_mapped;
    logic   pa_uncached;
    vpn_t   inst_vpn;
    pfn_t   inst_pfn;
    paddr_t inst_pa;
    logic   translation_ok;
    assign direct_mapped = inst_va[31:30] == KSEG_TOP;
    assign inst_vpn = inst_va[31:12];
    assign pa_uncached = direct_mapped ? inst_va[KSEG1_BIT] : itlb_uc;
    assign inst_pfn = direct_mapped ? pfn_t'({3'b000, inst_va[28:12]}) : itlb_pfn;
    assign inst_pa = {inst_pfn, inst_va[11:0]};
    assign translation_ok = direct_mapped || (itlb_valid && itlb_vpn == inst_vpn);

    // RAMs follow inst_va_next while results go straight to the CPU
    logic                      use_cur_va;
    logic [LEN_PER_WAY-4:0]    rd_word_addr;
    line_t                     rd_line_addr;
    line_t                     va_line;
    line_t                     fence_line;
    assign use_cur_va = state != idle && state != save_result;
    assign rd_word_addr = use_cur_va ? inst_va[LEN_PER_WAY-1:3] : inst_va_next[LEN_PER_WAY-1:3];
    assign rd_line_addr = use_cur_va ? inst_va[LEN_PER_WAY-1:LEN_LINE]
                                     : inst_va_next[LEN_PER_WAY-1:LEN_LINE];
    assign va_line = inst_va[LEN_PER_WAY-1:LEN_LINE];
    assign fence_line = fence_addr[LEN_PER_WAY-1:LEN_LINE];

    logic beat;
    assign beat = state == cache_replace && rvalid && rready;

    logic [63:0] way_data [2];
    tag_t        way_tag [2];
    logic [1:0]  way_hit;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic       way_sel;
        logic [1:0] data_mask;
        assign way_sel = repl_way == 1'(w);
        // beats alternate between the low and high word of a row
        assign data_mask = (beat && way_sel) ? (axi_cnt[0] ? 2'b10 : 2'b01) : 2'b00;

        icache_bram #(.LEN_DATA(64), .LEN_ADDR(LEN_PER_WAY - 3)) u_data (
            .clk     (clk),
            .wr_addr ({repl_line, axi_cnt[LEN_LINE-3:1]}),
            .wr_data ({rdata, rdata}),
            .wr_mask (data_mask),
            .rd_addr (rd_word_addr),
            .rd_data (way_data[w])
        );

        // tag lands together with the last beat
        icache_bram #(.LEN_DATA(LEN_TAG), .LEN_ADDR(LEN_INDEX)) u_tag (
            .clk     (clk),
            .wr_addr (repl_line),
            .wr_data (repl_tag),
            .wr_mask ({2{beat && rlast && way_sel}}),
            .rd_addr (rd_line_addr),
            .rd_data (way_tag[w])
        );

        assign way_hit[w] = way_tag[w] == inst_pa[31:LEN_PER_WAY] && line_valid[va_line][w];
    end

    logic  hit_way;
    logic  hit_ok;
    logic  accept;
    word_t cache_inst0;
    word_t cache_inst1;
    assign hit_way = way_hit[1];
    assign hit_ok = (|way_hit) && translation_ok && !pa_uncached;
    assign cache_inst0 = inst_va[2] ? way_data[hit_way][63:32] : way_data[hit_way][31:0];
    assign cache_inst1 = way_data[hit_way][63:32];

    assign istall = (state == idle) ? (!hit_ok && inst_en) : (state != save_result);
    assign accept = !istall && !stallF;

    assign inst_ok0 = ((state == idle) ? hit_ok : saved_ok0) && inst_en;
    assign inst_ok1 = (state == idle) && hit_ok && !inst_va[2] && inst_en;
    assign inst_rdata0 = (state == idle) ? cache_inst0 : saved_inst0;
    assign inst_rdata1 = (state == idle) ? cache_inst1 : '0;
    assign arsize = 3'd2;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            for (int k = 0; k < NR_LINES; k++) begin
                line_valid[k] <= 2'b00;
                line_lru[k] <= 1'b0;
            end
            itlb_valid <= 1'b0;
            itlb_vpn2 <= '0;
            tlb_wait <= 1'b0;
            inst_tlb_refill <= 1'b0;
            inst_tlb_invalid <= 1'b0;
            saved_ok0 <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
            axi_cnt <= '0;
        end else begin
            // fences only when the CPU is moving
            if (fence_tlb && accept) begin
                itlb_valid <= 1'b0;
            end
            if (fence_i && accept) begin
                line_valid[fence_line] <= 2'b00;
            end
            case (state)
                idle: begin
                    if (inst_en && !translation_ok) begin
                        itlb_vpn2 <= inst_va[31:13];
                        tlb_wait <= 1'b1;
                        state <= tlb_fill;
                    end else if (inst_en && pa_uncached) begin
                        araddr <= inst_pa;
                        arlen <= 8'd0;
                        arvalid <= 1'b1;
                        state <= uncached;
                    end else if (inst_en && !hit_ok) begin
                        araddr <= {inst_pa[31:LEN_LINE], {LEN_LINE{1'b0}}};
                        arlen <= 8'(NR_WORDS - 1);
                        arvalid <= 1'b1;
                        repl_line <= va_line;
                        repl_way <= line_lru[va_line];
                        repl_tag <= inst_pa[31:LEN_PER_WAY];
                        axi_cnt <= '0;
                        state <= cache_replace;
                    end else if (inst_en && accept) begin
                        line_lru[va_line] <= !hit_way;
                    end
                end
                tlb_fill: begin
                    // joint TLB answer is one cycle behind itlb_vpn2
                    if (tlb_wait) begin
                        tlb_wait <= 1'b0;
                    end else if (itlb_found && (inst_va[12] ? v1 : v0)) begin
                        itlb_vpn <= inst_vpn;
                        itlb_pfn <= inst_va[12] ? pfn1 : pfn0;
                        itlb_uc <= inst_va[12] ? !c1 : !c0;
                        itlb_valid <= 1'b1;
                        state <= idle;
                    end else begin
                        inst_tlb_refill <= !itlb_found;
                        inst_tlb_invalid <= itlb_found;
                        saved_inst0 <= '0;
                        saved_ok0 <= 1'b1;
                        state <= save_result;
                    end
                end
                uncached: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                    end else if (rvalid && rready) begin
                        rready <= 1'b0;
                        saved_inst0 <= rdata;
                        saved_ok0 <= 1'b1;
                        state <= save_result;
                    end
                end
                cache_replace: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            rready <= 1'b1;
                        end
                    end else if (beat) begin
                        axi_cnt <= axi_cnt + 1'b1;
                        if (rlast) begin
                            rready <= 1'b0;
                            line_valid[repl_line][repl_way] <= 1'b1;
                            line_lru[repl_line] <= !repl_way;
                        end
                    end else if (!rready) begin
                        // one spare cycle so the RAM read sees the last beat
                        state <= idle;
                    end
                end
                save_result: begin
                    if (!stallF) begin
                        inst_tlb_refill <= 1'b0;
                        inst_tlb_invalid <= 1'b0;
                        saved_ok0 <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/jtlb.sv */
`default_nettype none

module jtlb
    import tlb_pkg::*;
#(
    parameter int NR_ENTRIES = TLB_ENTRIES
) (
    input  logic     clk,
    input  logic     rst,
    // write port with one entry per strobe
    input  logic     tlbw_en,
    input  tlb_idx_t tlbw_index,
    input  vpn2_t    tlbw_vpn2,
    input  pfn_t     tlbw_pfn0,
    input  pfn_t     tlbw_pfn1,
    input  logic     tlbw_c0,
    input  logic     tlbw_c1,
    input  logic     tlbw_v0,
    input  logic     tlbw_v1,
    // lookup answered one cycle later
    input  vpn2_t    lookup_vpn2,
    output logic     found,
    output pfn_t     pfn0,
    output pfn_t     pfn1,
    output logic     c0,
    output logic     c1,
    output logic     v0,
    output logic     v1
);

    logic [NR_ENTRIES-1:0] present;
    vpn2_t ent_vpn2 [NR_ENTRIES];
    pfn_t  ent_pfn0 [NR_ENTRIES];
    pfn_t  ent_pfn1 [NR_ENTRIES];
    logic [NR_ENTRIES-1:0] ent_c0;
    logic [NR_ENTRIES-1:0] ent_c1;
    logic [NR_ENTRIES-1:0] ent_v0;
    logic [NR_ENTRIES-1:0] ent_v1;

    always_ff @(posedge clk) begin
        if (rst) begin
            present <= '0;
        end else if (tlbw_en) begin
            present[tlbw_index] <= 1'b1;
        end
    end

    // entry contents written by index
    always_ff @(posedge clk) begin
        if (tlbw_en) begin
            ent_vpn2[tlbw_index] <= tlbw_vpn2;
            ent_pfn0[tlbw_index] <= tlbw_pfn0;
            ent_pfn1[tlbw_index] <= tlbw_pfn1;
            ent_c0[tlbw_index] <= tlbw_c0;
            ent_c1[tlbw_index] <= tlbw_c1;
            ent_v0[tlbw_index] <= tlbw_v0;
            ent_v1[tlbw_index] <= tlbw_v1;
        end
    end

    // parallel compare where the lowest matching index wins
    logic     hit_any;
    tlb_idx_t hit_idx;
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int k = NR_ENTRIES - 1; k >= 0; k--) begin
            if (present[k] && ent_vpn2[k] == lookup_vpn2) begin
                hit_any = 1'b1;
                hit_idx = tlb_idx_t'(k);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            found <= 1'b0;
        end else begin
            found <= hit_any;
        end
    end

    always_ff @(posedge clk) begin
        pfn0 <= ent_pfn0[hit_idx];
        pfn1 <= ent_pfn1[hit_idx];
        c0 <= ent_c0[hit_idx];
        c1 <= ent_c1[hit_idx];
        v0 <= ent_v0[hit_idx];
        v1 <= ent_v1[hit_idx];
    end

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`default_nettype none

module fetch_top
    import mips_addr_pkg::*;
    import tlb_pkg::*;
#(
    parameter int LEN_LINE   = 6,
    parameter int LEN_INDEX  = 6,
    parameter int NR_ENTRIES = TLB_ENTRIES
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_en,
    input  vaddr_t     inst_va,
    input  vaddr_t     inst_va_next,
    output word_t      inst_rdata0,
    output word_t      inst_rdata1,
    output logic       inst_ok0,
    output logic       inst_ok1,
    output logic       inst_tlb_refill,
    output logic       inst_tlb_invalid,
    input  logic       stallF,
    output logic       istall,
    input  logic       fence_i,
    input  vaddr_t     fence_addr,
    input  logic       fence_tlb,
    input  logic       tlbw_en,
    input  tlb_idx_t   tlbw_index,
    input  vpn2_t      tlbw_vpn2,
    input  pfn_t       tlbw_pfn0,
    input  pfn_t       tlbw_pfn1,
    input  logic       tlbw_c0,
    input  logic       tlbw_c1,
    input  logic       tlbw_v0,
    input  logic       tlbw_v1,
    output paddr_t     araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready
);

    // cache to joint TLB
    vpn2_t itlb_vpn2;
    logic  itlb_found;
    pfn_t  itlb_pfn0;
    pfn_t  itlb_pfn1;
    logic  itlb_c0;
    logic  itlb_c1;
    logic  itlb_v0;
    logic  itlb_v1;

    icache #(.LEN_LINE(LEN_LINE), .LEN_INDEX(LEN_INDEX)) u_icache (
        .clk              (clk),
        .rst              (rst),
        .inst_en          (inst_en),
        .inst_va          (inst_va),
        .inst_va_next     (inst_va_next),
        .inst_rdata0      (inst_rdata0),
        .inst_rdata1      (inst_rdata1),
        .inst_ok0         (inst_ok0),
        .inst_ok1         (inst_ok1),
        .inst_tlb_refill  (inst_tlb_refill),
        .inst_tlb_invalid (inst_tlb_invalid),
        .stallF           (stallF),
        .istall           (istall),
        .fence_i          (fence_i),
        .fence_addr       (fence_addr),
        .fence_tlb        (fence_tlb),
        .itlb_vpn2        (itlb_vpn2),
        .itlb_found       (itlb_found),
        .pfn0             (itlb_pfn0),
        .pfn1             (itlb_pfn1),
        .c0               (itlb_c0),
        .c1               (itlb_c1),
        .v0               (itlb_v0),
        .v1               (itlb_v1),
        .araddr           (araddr),
        .arlen            (arlen),
        .arsize           (arsize),
        .arvalid          (arvalid),
        .arready          (arready),
        .rdata            (rdata),
        .rlast            (rlast),
        .rvalid           (rvalid),
        .rready           (rready)
    );

    jtlb #(.NR_ENTRIES(NR_ENTRIES)) u_jtlb (
        .clk         (clk),
        .rst         (rst),
        .tlbw_en     (tlbw_en),
        .tlbw_index  (tlbw_index),
        .tlbw_vpn2   (tlbw_vpn2),
        .tlbw_pfn0   (tlbw_pfn0),
        .tlbw_pfn1   (tlbw_pfn1),
        .tlbw_c0     (tlbw_c0),
        .tlbw_c1     (tlbw_c1),
        .tlbw_v0     (tlbw_v0),
        .tlbw_v1     (tlbw_v1),
        .lookup_vpn2 (itlb_vpn2),
        .found       (itlb_found),
        .pfn0        (itlb_pfn0),
        .pfn1        (itlb_pfn1),
        .c0          (itlb_c0),
        .c1          (itlb_c1),
        .v0          (itlb_v0),
        .v1          (itlb_v1)
    );

endmodule

`default_nettype wire

/* testbench/fetch_assert.sv */
`default_nettype none

module fetch_assert
    import mips_addr_pkg::*;
(
    input wire logic  clk,
    input wire logic  rst,
    input wire logic  arvalid,
    input wire logic  arready,
    input wire logic  rready,
    input wire logic  inst_ok0,
    input wire logic  inst_tlb_refill,
    input wire logic  inst_tlb_invalid,
    input wire word_t inst_rdata0
);

    timeunit 1ns;
    timeprecision 100ps;

    // address stays offered until taken
    a_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // data phase only after the address phase
    a_rready_after_ar: assert property (@(posedge clk) disable iff (rst)
        !(rready && arvalid))
        else $error("rready high while arvalid high");

    a_exception_data: assert property (@(posedge clk) disable iff (rst)
        inst_ok0 && (inst_tlb_refill || inst_tlb_invalid) |-> inst_rdata0 == '0)
        else $error("exception result carries nonzero data");

endmodule

bind fetch_top fetch_assert u_fetch_assert (.*);

`default_nettype wire

/* testbench/tb_fetch.sv */
`default_nettype none

module tb_fetch
    import mips_addr_pkg::*;
    import tlb_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t DATA_KEY = 32'hc0de_0000;
    // four bytes per beat
    localparam logic [2:0] BEAT_SIZE = 3'd2;
    localparam int FETCH_TIMEOUT = 400;
    localparam int RUN_LIMIT = 40000;

    logic clk = 1'b0;
    logic rst;
    logic inst_en, stallF, fence_i, fence_tlb;
    vaddr_t inst_va, inst_va_next, fence_addr;
    word_t inst_rdata0, inst_rdata1;
    logic inst_ok0, inst_ok1, inst_tlb_refill, inst_tlb_invalid, istall;
    logic tlbw_en, tlbw_c0, tlbw_c1, tlbw_v0, tlbw_v1;
    tlb_idx_t tlbw_index;
    vpn2_t tlbw_vpn2;
    pfn_t tlbw_pfn0, tlbw_pfn1;
    paddr_t araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic arvalid, arready, rlast, rvalid, rready;
    word_t rdata;

    // memory model state
    logic [31:0] lfsr_state = 32'h9f5a;
    logic [1:0] ar_wait, r_wait;
    logic [8:0] beats_left;
    paddr_t beat_addr, last_araddr;
    logic [7:0] last_arlen;
    logic [2:0] last_arsize;
    logic beat_taken;
    int burst_cnt = 0;

    int errors = 0;
    int checks = 0;
    int tests = 0;

    always #20 clk = !clk;

    fetch_top dut_i (.*);

    // galois LFSR stepped once per bit
    function automatic logic [1:0] random_delay();
        logic [1:0] d;
        d = '0;
        for (int k = 0; k < 2; k++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            d = {d[0], lfsr_state[0]};
        end
        return d;
    endfunction

    // AXI read slave with random arready and rvalid delays
    always @(posedge clk) begin
        beat_taken = rvalid && rready;
        if (!rst && arvalid && arready) begin
            burst_cnt++;
            last_araddr = araddr;
            last_arlen = arlen;
            last_arsize = arsize;
            beat_addr = araddr;
            beats_left = 9'(arlen) + 9'd1;
            ar_wait = random_delay();
            r_wait = random_delay();
        end
        if (!rst && beat_taken) begin
            beat_addr = beat_addr + 32'd4;
            beats_left = beats_left - 9'd1;
            r_wait = random_delay();
        end
        #1;
        if (rst) begin
            arready = 1'b0;
            rvalid = 1'b0;
            rlast = 1'b0;
            rdata = '0;
            beats_left = '0;
            ar_wait = random_delay();
            r_wait = '0;
        end else begin
            if (arvalid && ar_wait != 0) begin
                ar_wait = ar_wait - 2'd1;
                arready = 1'b0;
            end else begin
                arready = arvalid;
            end
            if (beat_taken) begin
                rvalid = 1'b0;
            end
            if (!rvalid && beats_left != 0) begin
                if (r_wait != 0) begin
                    r_wait = r_wait - 2'd1;
                end else begin
                    rvalid = 1'b1;
                    rdata = beat_addr ^ DATA_KEY;
                    rlast = beats_left == 9'd1;
                end
            end
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_tlb(input logic [31:0] f[8]);
        @(posedge clk);
        #1;
        tlbw_index = tlb_idx_t'(f[0]);
        tlbw_vpn2 = vpn2_t'(f[1]);
        tlbw_pfn0 = pfn_t'(f[2]);
        tlbw_pfn1 = pfn_t'(f[3]);
        tlbw_c0 = f[4][0];
        tlbw_c1 = f[5][0];
        tlbw_v0 = f[6][0];
        tlbw_v1 = f[7][0];
        tlbw_en = 1'b1;
        @(posedge clk);
        #1;
        tlbw_en = 1'b0;
    endtask

    task automatic pulse_fence(input logic is_tlb, input vaddr_t addr);
        @(posedge clk);
        #1;
        fence_addr = addr;
        fence_i = !is_tlb;
        fence_tlb = is_tlb;
        @(posedge clk);
        #1;
        fence_i = 1'b0;
        fence_tlb = 1'b0;
    endtask

    task automatic run_fetch(input vaddr_t va, input logic [63:0] kind, input int exp_bursts,
                             input paddr_t exp_araddr, input logic [7:0] exp_arlen,
                             input paddr_t exp_pa);
        int waited;
        int bursts_before;
        int errors_before;
        logic both;
        bursts_before = burst_cnt;
        errors_before = errors;
        both = kind == "h" && !va[2];
        // RAMs are read with inst_va_next one cycle ahead
        @(posedge clk);
        #1;
        inst_en = 1'b0;
        inst_va = va;
        inst_va_next = va;
        @(posedge clk);
        #1;
        inst_en = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!(inst_ok0 && !istall) && waited < FETCH_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= FETCH_TIMEOUT) begin
            $display("timeout: no fetch result for address %h", va);
            $display("Checks failed");
            $finish;
        end else begin
            if (kind == "r" || kind == "i") begin
                check("inst_rdata0", inst_rdata0, '0);
            end else begin
                check("inst_rdata0", inst_rdata0, exp_pa ^ DATA_KEY);
            end
            check("inst_tlb_refill", 32'(inst_tlb_refill), 32'(kind == "r"));
            check("inst_tlb_invalid", 32'(inst_tlb_invalid), 32'(kind == "i"));
            check("inst_ok1", 32'(inst_ok1), 32'(both));
            if (both) begin
                check("inst_rdata1", inst_rdata1, (exp_pa + 32'd4) ^ DATA_KEY);
            end
            @(posedge clk);
            #1;
            inst_en = 1'b0;
            check("burst count", 32'(burst_cnt - bursts_before), 32'(exp_bursts));
            if (exp_bursts == 1) begin
                check("araddr", last_araddr, exp_araddr);
                check("arlen", 32'(last_arlen), 32'(exp_arlen));
                check("arsize", 32'(last_arsize), 32'(BEAT_SIZE));
            end
            tests++;
            $display("test %0d fetch %h kind %0s: %0s", tests, va, kind,
                     (errors == errors_before) ? "ok" : "mismatch");
        end
    endtask

    initial begin
        int fd;
        int code;
        logic [63:0] cmd;
        logic [63:0] kind;
        logic [31:0] f[8];
        logic [8*160-1:0] rest;
        rst = 1'b1;
        inst_en = 1'b0;
        inst_va = '0;
        inst_va_next = '0;
        stallF = 1'b0;
        fence_i = 1'b0;
        fence_tlb = 1'b0;
        fence_addr = '0;
        tlbw_en = 1'b0;
        tlbw_index = '0;
        tlbw_vpn2 = '0;
        tlbw_pfn0 = '0;
        tlbw_pfn1 = '0;
        tlbw_c0 = 1'b0;
        tlbw_c1 = 1'b0;
        tlbw_v0 = 1'b0;
        tlbw_v1 = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        rdata = '0;
        fd = $fopen("testbench/fetch_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/fetch_golden.txt");
            $display("Checks failed");
            $finish;
        end else begin
            repeat (8) @(posedge clk);
            #1;
            rst = 1'b0;
            while (!$feof(fd)) begin
                cmd = '0;
                code = $fscanf(fd, "%s", cmd);
                if (code == 1) begin
                    case (cmd)
                        "#": code = $fgets(rest, fd);
                        "w": begin
                            code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                            write_tlb(f);
                        end
                        "f": begin
                            kind = '0;
                            code = $fscanf(fd, "%h %s %h %h %h %h",
                                           f[0], kind, f[1], f[2], f[3], f[4]);
                            run_fetch(f[0], kind, int'(f[1]), f[2], f[3][7:0], f[4]);
                        end
                        "i": begin
                            code = $fscanf(fd, "%h", f[0]);
                            pulse_fence(1'b0, f[0]);
                        end
                        "t": begin
                            code = $fscanf(fd, "%h", f[0]);
                            pulse_fence(1'b1, f[0]);
                        end
                        default: begin
                            errors++;
                            $display("unknown golden command %0s", cmd);
                        end
                    endcase
                end
            end
            $fclose(fd);
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("simulation ran past its cycle limit");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/fetch_golden.txt */
# w index vpn2 pfn0 pfn1 c0 c1 v0 v1 : TLB write, all hex
# f va kind bursts araddr arlen pa : kind h cached, u uncached, r refill, i invalid
# i va : fence_i on the line of va ; t 0 : fence_tlb
# kseg0 line miss, then hits in the same line
f 80001000 h 1 00001000 0f 00001000
f 80001008 h 0 0 0 00001008
f 8000103c h 0 0 0 0000103c
# kseg1 single beats, never allocated
f a0002004 u 1 00002004 00 00002004
f a0002004 u 1 00002004 00 00002004
# mapped pair, even page cached, odd page uncached
w 0 00200 00120 00135 1 0 1 1
f 00400010 h 1 00120000 0f 00120010
f 00401020 u 1 00135020 00 00135020
# no matching entry, then an entry with the even half invalid
f 00800000 r 0 0 0 0
w 1 00600 00140 00141 1 1 0 1
f 00c00040 i 0 0 0 0
# fence_i drops index 0 in both ways
i 80001000
f 80001000 h 1 00001000 0f 00001000
f 00400018 h 1 00120000 0f 00120018
# fence_tlb then remap to a new frame
t 0
w 0 00200 00150 00151 1 1 1 1
f 00400010 h 1 00150000 0f 00150010
# three lines on index 1, LRU replacement
f 80003040 h 1 00003040 0f 00003040
f 80004040 h 1 00004040 0f 00004040
f 80003048 h 0 0 0 00003048
f 80005040 h 1 00005040 0f 00005040
f 80003040 h 0 0 0 00003040
f 80004040 h 1 00004040 0f 00004040

/* fetch_top.f */
common/mips_addr_pkg.sv
common/tlb_pkg.sv
icache/icache_bram.sv
icache/icache.sv
logic/jtlb.sv
logic/fetch_top.sv
testbench/fetch_assert.sv
testbench/tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - common/mips_addr_pkg.sv
  - common/tlb_pkg.sv
  - icache/icache_bram.sv
  - icache/icache.sv
  - logic/jtlb.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - testbench/fetch_assert.sv
      - testbench/tb_fetch.sv
